// File: sim.f
logic/mips_pkg.sv
logic/ctrl_if.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_load_select.sv
logic/mips_control.sv
logic/mips_datapath.sv
logic/mips_cpu.sv
test/tb_mem.sv
test/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu

sources:
  - logic/mips_pkg.sv
  - logic/ctrl_if.sv
  - logic/mips_regfile.sv
  - logic/mips_alu.sv
  - logic/mips_load_select.sv
  - logic/mips_control.sv
  - logic/mips_datapath.sv
  - logic/mips_cpu.sv
  - target: test
    files:
      - test/tb_mem.sv
      - test/mips_cpu_tb.sv

// File: test/mips_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb;

  logic        clk;
  logic        rst_n;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic [31:0] data_writedata;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_readdata;

  logic [31:0] prog [1024];     // Program image that is also the model's fetch source
  int unsigned prog_len;
  logic        checking;        // Comparisons run once reset is over
  int unsigned hold_left;       // Remaining cycles of a disabled stretch
  int unsigned drive_cycles;

  // Reference state of the instruction-set model
  logic [31:0] model_pc;
  logic [31:0] model_npc;       // Delay-slot successor
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [256];
  logic        model_active;
  logic        exp_store;       // Current instruction is a store
  logic        exp_load;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;

  mips_cpu DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_readdata  (data_readdata)
  );

  tb_mem u_mem (
    .clk            (clk),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_readdata  (data_readdata)
  );

  always #5 clk = ~clk; // 10 ns period

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 32'h%08h, expected 32'h%08h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Encoders fill the instruction union field by field
  function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] shamt,
                                         input logic [5:0] funct);
    mips_pkg::instr_t w;
    w.r.opcode = mips_pkg::op_special;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = shamt;
    w.r.funct  = funct;
    return w;
  endfunction

  function automatic logic [31:0] i_word(input logic [5:0] opcode, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    mips_pkg::instr_t w;
    w.i.opcode = opcode;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic logic [31:0] j_word(input logic [5:0] opcode, input logic [31:0] target);
    mips_pkg::instr_t w;
    w.j.opcode = opcode;
    w.j.target = target[27:2]; // Region bits come from the delay slot address
    return w;
  endfunction

  function automatic logic [31:0] here();
    return mips_pkg::reset_vector + 4 * prog_len; // Address of the next emitted word
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len = prog_len + 1;
  endtask

  task automatic load_address(input logic [4:0] rt, input logic [31:0] value);
    emit(i_word(mips_pkg::op_lui, 5'd0, rt, value[31:16]));
    emit(i_word(mips_pkg::op_ori, rt, rt, value[15:0])); // ori zero-extends the low half
  endtask

  // Registers 0 to 7 only, so v0 and $0 are hit often
  function automatic logic [31:0] random_alu_word();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [31:0] w;
    rs    = $urandom % 8;
    rt    = $urandom % 8;
    rd    = $urandom % 8;
    shamt = $urandom % 32;
    imm   = $urandom;
    case ($urandom % 17)
      0:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_addu);
      1:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_subu);
      2:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_and);
      3:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_or);
      4:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_xor);
      5:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_slt);
      6:  w = r_word(rs, rt, rd, 5'd0, mips_pkg::fn_sltu);
      7:  w = r_word(5'd0, rt, rd, shamt, mips_pkg::fn_sll);
      8:  w = r_word(5'd0, rt, rd, shamt, mips_pkg::fn_srl);
      9:  w = r_word(5'd0, rt, rd, shamt, mips_pkg::fn_sra);
      10: w = i_word(mips_pkg::op_addiu, rs, rd, imm);
      11: w = i_word(mips_pkg::op_andi, rs, rd, imm);
      12: w = i_word(mips_pkg::op_ori, rs, rd, imm);
      13: w = i_word(mips_pkg::op_xori, rs, rd, imm);
      14: w = i_word(mips_pkg::op_slti, rs, rd, imm);
      15: w = i_word(mips_pkg::op_sltiu, rs, rd, imm);
      default: w = i_word(mips_pkg::op_lui, 5'd0, rd, imm);
    endcase
    return w;
  endfunction

  // Data fill mixes every address bit so misplaced accesses show up
  function automatic logic [31:0] fill_word(input int unsigned index);
    logic [31:0] addr;
    addr = index * 4;
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  task automatic build_program();
    logic [31:0] t;
    prog_len = 0;
    for (int i = 0; i < 1024; i++) begin
      prog[i] = 32'h0000_0000; // nop everywhere else
    end
    repeat (200) emit(random_alu_word());
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd8, 16'd5));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd9, 16'd5));
    emit(i_word(mips_pkg::op_beq, 5'd8, 5'd9, 16'd2));       // Taken
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0011));  // Delay slot runs
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));  // Skipped
    emit(i_word(mips_pkg::op_bne, 5'd8, 5'd9, 16'd2));       // Not taken
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd1));
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd2));     // Falls through
    emit(i_word(mips_pkg::op_bne, 5'd8, 5'd0, 16'd2));       // Taken
    emit(r_word(5'd2, 5'd8, 5'd2, 5'd0, mips_pkg::fn_addu));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
    emit(i_word(mips_pkg::op_beq, 5'd8, 5'd0, 16'd2));       // Not taken
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd3));
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd4));
    // Three-pass loop with a backward branch
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd11, 16'd3));
    emit(i_word(mips_pkg::op_addiu, 5'd11, 5'd11, 16'hFFFF));
    emit(i_word(mips_pkg::op_bne, 5'd11, 5'd0, 16'hFFFE));
    emit(r_word(5'd2, 5'd11, 5'd2, 5'd0, mips_pkg::fn_addu));
    t = here() + 12;
    emit(j_word(mips_pkg::op_j, t));
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd5));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
    t = here() + 20; // Past lui, ori, jr, its delay slot and one skipped word
    load_address(5'd10, t);
    emit(r_word(5'd10, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
    emit(i_word(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd6));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
    // Store a word with mixed sign bits, then read it back every way
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd12, 16'h0100));
    load_address(5'd13, 32'h8A7F_1C93);
    emit(i_word(mips_pkg::op_sw, 5'd12, 5'd13, 16'd0));
    emit(i_word(mips_pkg::op_lw, 5'd12, 5'd2, 16'd0));
    for (int k = 0; k < 4; k++) begin
      emit(i_word(mips_pkg::op_lb, 5'd12, 5'd2, k));
      emit(i_word(mips_pkg::op_lbu, 5'd12, 5'd2, k));
      emit(i_word(mips_pkg::op_lh, 5'd12, 5'd2, k));
      emit(i_word(mips_pkg::op_lhu, 5'd12, 5'd2, k));
    end
    emit(i_word(mips_pkg::op_sw, 5'd12, 5'd2, 16'd4));
    emit(i_word(mips_pkg::op_lw, 5'd12, 5'd2, 16'd4));
    emit(i_word(mips_pkg::op_lw, 5'd12, 5'd2, 16'hFFF8));  // Untouched fill word
    emit(i_word(mips_pkg::op_lb, 5'd12, 5'd2, 16'h0013));
    t = here() + 12;
    emit(j_word(mips_pkg::op_jal, t));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0044));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
    emit(r_word(5'd31, 5'd0, 5'd2, 5'd0, mips_pkg::fn_addu)); // Return address into v0
    t = here() + 20;
    load_address(5'd14, t);
    emit(r_word(5'd14, 5'd0, 5'd15, 5'd0, mips_pkg::fn_jalr));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0055));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
    emit(r_word(5'd15, 5'd0, 5'd2, 5'd0, mips_pkg::fn_addu));
    // Jump to address 0 ends the run after the delay slot
    emit(r_word(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'h0077));
    emit(i_word(mips_pkg::op_addiu, 5'd0, 5'd2, 16'hDEAD));
  endtask

  // Executes the instruction at model_pc and advances the model by one step
  function automatic void iss_step();
    mips_pkg::instr_t iw;
    logic [31:0] rs_v;
    logic [31:0] rt_v;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] pc4;
    logic [31:0] next_npc;
    logic [31:0] result;
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    logic [4:0]  dest;
    logic        wr;
    iw       = prog[model_pc[11:2]];
    rs_v     = model_regs[iw.r.rs];
    rt_v     = model_regs[iw.r.rt];
    simm     = {{16{iw.i.imm[15]}}, iw.i.imm};
    zimm     = {16'h0000, iw.i.imm};
    pc4      = model_pc + 4;
    next_npc = model_npc + 4; // Straight-line successor of the delay slot
    result   = 32'h0;
    dest     = iw.i.rt;
    wr       = 1'b0;
    exp_store = 1'b0;
    exp_load  = 1'b0;
    exp_addr  = rs_v + simm;
    exp_data  = rt_v;
    case (iw.r.opcode)
      mips_pkg::op_special: begin
        dest = iw.r.rd;
        wr   = 1'b1;
        case (iw.r.funct)
          mips_pkg::fn_addu: result = rs_v + rt_v;
          mips_pkg::fn_subu: result = rs_v - rt_v;
          mips_pkg::fn_and:  result = rs_v & rt_v;
          mips_pkg::fn_or:   result = rs_v | rt_v;
          mips_pkg::fn_xor:  result = rs_v ^ rt_v;
          mips_pkg::fn_slt:  result = {31'd0, $signed(rs_v) < $signed(rt_v)};
          mips_pkg::fn_sltu: result = {31'd0, rs_v < rt_v};
          mips_pkg::fn_sll:  result = rt_v << iw.r.shamt;
          mips_pkg::fn_srl:  result = rt_v >> iw.r.shamt;
          mips_pkg::fn_sra:  result = $signed(rt_v) >>> iw.r.shamt;
          mips_pkg::fn_jr: begin
            wr       = 1'b0;
            next_npc = rs_v;
          end
          mips_pkg::fn_jalr: begin
            result   = model_pc + 8;
            next_npc = rs_v;
          end
          default: wr = 1'b0;
        endcase
      end
      mips_pkg::op_addiu: begin
        wr     = 1'b1;
        result = rs_v + simm;
      end
      mips_pkg::op_andi: begin
        wr     = 1'b1;
        result = rs_v & zimm;
      end
      mips_pkg::op_ori: begin
        wr     = 1'b1;
        result = rs_v | zimm;
      end
      mips_pkg::op_xori: begin
        wr     = 1'b1;
        result = rs_v ^ zimm;
      end
      mips_pkg::op_slti: begin
        wr     = 1'b1;
        result = {31'd0, $signed(rs_v) < $signed(simm)};
      end
      mips_pkg::op_sltiu: begin
        wr     = 1'b1;
        result = {31'd0, rs_v < simm}; // Sign-extended and then compared unsigned
      end
      mips_pkg::op_lui: begin
        wr     = 1'b1;
        result = {iw.i.imm, 16'h0000};
      end
      mips_pkg::op_beq: if (rs_v == rt_v) next_npc = pc4 + (simm << 2);
      mips_pkg::op_bne: if (rs_v != rt_v) next_npc = pc4 + (simm << 2);
      mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu, mips_pkg::op_lh,
      mips_pkg::op_lhu: begin
        wr       = 1'b1;
        exp_load = 1'b1;
        word     = model_mem[exp_addr[9:2]];
        b        = word >> (8 * exp_addr[1:0]); // Little-endian byte lanes
        h        = word >> (16 * exp_addr[1]);  // Halfword lanes follow address bit 1
        case (iw.i.opcode)
          mips_pkg::op_lb:  result = {{24{b[7]}}, b};
          mips_pkg::op_lbu: result = {24'd0, b};
          mips_pkg::op_lh:  result = {{16{h[15]}}, h};
          mips_pkg::op_lhu: result = {16'd0, h};
          default:          result = word;
        endcase
      end
      mips_pkg::op_sw: begin
        exp_store = 1'b1;
        model_mem[exp_addr[9:2]] = rt_v;
      end
      mips_pkg::op_j: next_npc = {pc4[31:28], iw.j.target, 2'b00};
      mips_pkg::op_jal: begin
        wr       = 1'b1;
        dest     = mips_pkg::link_reg;
        result   = model_pc + 8;
        next_npc = {pc4[31:28], iw.j.target, 2'b00};
      end
      default: ;
    endcase
    if (wr && dest != 5'd0) model_regs[dest] = result; // $0 stays zero
    model_pc  = model_npc;
    model_npc = next_npc;
    if (model_pc == 32'h0) model_active = 1'b0; // Halt on reaching address 0
  endfunction

  // Outputs are settled at the falling edge and the next rising edge applies them
  always @(negedge clk) begin
    if (checking) begin
      compare("instr_address", instr_address, model_pc);
      compare("active", active, model_active);
      compare("register_v0", register_v0, model_regs[mips_pkg::v0_reg]);
      if (clk_enable && model_active) begin
        iss_step();
        compare("data_write", data_write, exp_store);
        compare("data_read", data_read, exp_load);
        if (exp_store || exp_load) begin
          compare("data_address", data_address, exp_addr);
        end
        if (exp_store) compare("data_writedata", data_writedata, exp_data);
      end else begin
        compare("data_write", data_write, 1'b0); // Held cycles never store
        compare("data_read", data_read, 1'b0);
      end
    end
  end

  // Random disabled stretches of one to five cycles after a settling period
  always @(posedge clk) begin
    #1;
    drive_cycles = drive_cycles + 1;
    if (drive_cycles < 12) begin
      clk_enable = 1'b1;
    end else if (hold_left != 0) begin
      clk_enable = 1'b0;
      hold_left  = hold_left - 1;
    end else if ($urandom % 10 == 0) begin
      clk_enable = 1'b0;
      hold_left  = $urandom % 5;
    end else begin
      clk_enable = 1'b1;
    end
  end

  initial begin
    int unsigned first_draw;
    int unsigned waited;
    first_draw   = $urandom(32'h3aa7_4a4e); // Seeds the generator for the whole run
    clk          = 1'b0;
    rst_n        = 1'b0;
    clk_enable   = 1'b1;
    checking     = 1'b0;
    hold_left    = 0;
    drive_cycles = 0;
    build_program();
    for (int i = 0; i < 1024; i++) begin
      u_mem.rom[i] = prog[i];
    end
    for (int i = 0; i < 256; i++) begin
      u_mem.ram[i]  = fill_word(i);
      model_mem[i]  = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'h0;
    end
    model_pc     = mips_pkg::reset_vector;
    model_npc    = mips_pkg::reset_vector + 4;
    model_active = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    compare("instr_address", instr_address, mips_pkg::reset_vector);
    compare("active", active, 1'b1);
    compare("data_write", data_write, 1'b0);
    checking = 1'b1;
    waited   = 0;
    while (active && waited < 20000) begin
      @(posedge clk);
      #2;
      waited = waited + 1;
    end
    if (active) begin
      $display("Timeout: the processor never halted after 20000 cycles");
      $display("TEST FAILED");
      $fatal(1, "No halt");
    end
    // Halted core must stay at address 0 whatever clk_enable does
    repeat (6) begin
      @(posedge clk);
      #2;
      compare("instr_address", instr_address, 32'h0);
      compare("active", active, 1'b0);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction ROM and data RAM for the CPU testbench, both read within the cycle
module tb_mem (
  input  logic        clk,
  input  logic [31:0] instr_address,
  output logic [31:0] instr_readdata,
  input  logic [31:0] data_address,
  input  logic [31:0] data_writedata,
  input  logic        data_write,
  output logic [31:0] data_readdata
);

  logic [31:0] rom [1024]; // 4 KB window, the reset vector maps to word 0
  logic [31:0] ram [256];  // 1 KB of data, upper address bits are ignored

  // Upper address bits fold away so every fetch lands in the window
  assign instr_readdata = rom[instr_address[11:2]];
  assign data_readdata  = ram[data_address[9:2]]; // Whole word, the CPU picks bytes itself

  // Only whole-word stores exist, so no byte enables
  always @(posedge clk) begin
    if (data_write) begin
      ram[data_address[9:2]] <= data_writedata;
    end
  end

endmodule

`default_nettype wire

// File: logic/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] register_v0,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic [31:0] data_writedata,
  output logic        data_write,
  output logic        data_read,
  input  logic [31:0] data_readdata
);

  // Control levels for the instruction now on instr_readdata
  ctrl_if u_ctrl ();

  mips_control u_control (
    .instr (instr_readdata),
    .ctl   (u_ctrl.ctl)
  );

  // Both memories answer within the cycle, so one edge retires one instruction
  mips_datapath u_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .dp             (u_ctrl.dp),
    .instr          (instr_readdata),
    .instr_address  (instr_address),
    .data_readdata  (data_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),     // Gated by clk_enable and active
    .data_read      (data_read),
    .register_v0    (register_v0)
  );

endmodule

`default_nettype wire

// File: logic/mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mips_datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clk_enable,
  output logic             active,
  ctrl_if.dp               dp,
  input  mips_pkg::instr_t instr,
  output logic [31:0]      instr_address,
  input  logic [31:0]      data_readdata,
  output logic [31:0]      data_address,
  output logic [31:0]      data_writedata,
  output logic             data_write,
  output logic             data_read,
  output logic [31:0]      register_v0
);

  logic        step_en;       // One instruction retires on this edge
  logic [31:0] pc_q;          // Address of the instruction now executing
  logic [31:0] npc_q;         // Address of the one after it, the delay slot register
  logic [31:0] npc_d;
  logic [31:0] pc_plus4;
  logic [31:0] pc_plus8;
  logic [31:0] imm_ext;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_b;
  logic [31:0] alu_y;
  logic [31:0] load_data;
  logic [4:0]  write_reg;
  logic [31:0] write_data;
  logic        reg_we;

  // Nothing moves while disabled or after the halt
  assign step_en = clk_enable & active;

  assign instr_address = pc_q;
  assign pc_plus4      = pc_q + 32'd4;
  assign pc_plus8      = pc_q + 32'd8; // Return address skips the delay slot

  // Logical immediates are zero-extended, all others sign-extended
  assign imm_ext = dp.imm_zero_ext ? {16'h0000, instr.i.imm}
                                   : {{16{instr.i.imm[15]}}, instr.i.imm};

  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j.target, 2'b00}; // Region of the delay slot

  // The next-address register takes a target only when control flow changes
  always_comb begin
    if (dp.jump_reg) begin
      npc_d = rs_data;
    end else if (dp.jump) begin
      npc_d = jump_target;
    end else if (dp.take_branch) begin
      npc_d = branch_target;
    end else begin
      npc_d = npc_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q   <= mips_pkg::reset_vector;
      npc_q  <= mips_pkg::reset_vector + 32'd4;
      active <= 1'b1;
    end else if (step_en) begin
      pc_q   <= npc_q;          // The delay slot always follows
      npc_q  <= npc_d;
      active <= (npc_q != '0);  // Reaching address 0 stops the core
    end
  end

  // rd wins for R-type and jalr, jal falls back to ra
  assign write_reg = dp.reg_dst_rd ? instr.r.rd :
                     dp.link       ? mips_pkg::link_reg : instr.i.rt;

  assign write_data = dp.link       ? pc_plus8  :
                      dp.mem_to_reg ? load_data : alu_y;

  assign reg_we = dp.reg_write & step_en;

  mips_regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_en    (reg_we),
    .read_addr_a (instr.i.rs),
    .read_addr_b (instr.i.rt),
    .write_addr  (write_reg),
    .write_data  (write_data),
    .read_data_a (rs_data),
    .read_data_b (rt_data),
    .reg_v0      (register_v0)
  );

  assign alu_b = dp.alu_src_imm ? imm_ext : rt_data;

  mips_alu u_alu (
    .op    (dp.alu_op),
    .a     (rs_data),
    .b     (alu_b),
    .shamt (instr.r.shamt),
    .y     (alu_y),
    .zero  (dp.zero)
  );

  mips_load_select u_load_select (
    .mode        (dp.load_mode),
    .byte_offset (alu_y[1:0]),
    .word        (data_readdata),
    .y           (load_data)
  );

  assign data_address   = alu_y;   // Effective address of loads and stores
  assign data_writedata = rt_data;
  // Strobes follow the same condition as every state update
  assign data_write = dp.mem_write & step_en;
  assign data_read  = dp.mem_read & step_en;

endmodule

`default_nettype wire

// File: logic/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control (
  input  mips_pkg::instr_t instr,
  ctrl_if.ctl              ctl
);

  logic is_beq;
  logic is_bne;

  assign is_beq = (instr.i.opcode == mips_pkg::op_beq);
  assign is_bne = (instr.i.opcode == mips_pkg::op_bne);

  // Branch decision made here and nowhere else, bne wants a nonzero difference
  assign ctl.take_branch = (is_beq & ctl.zero) | (is_bne & ~ctl.zero);

  always_comb begin
    // Anything not listed below behaves as a nop
    ctl.reg_write    = 1'b0;
    ctl.reg_dst_rd   = 1'b0;
    ctl.link         = 1'b0;
    ctl.mem_to_reg   = 1'b0;
    ctl.alu_src_imm  = 1'b0;
    ctl.imm_zero_ext = 1'b0;
    ctl.alu_op       = mips_pkg::alu_add;
    ctl.load_mode    = mips_pkg::ld_word;
    ctl.jump         = 1'b0;
    ctl.jump_reg     = 1'b0;
    ctl.mem_write    = 1'b0;
    ctl.mem_read     = 1'b0;

    case (instr.i.opcode)
      mips_pkg::op_special: begin
        ctl.reg_write  = 1'b1;
        ctl.reg_dst_rd = 1'b1;
        case (instr.r.funct)
          mips_pkg::fn_addu: ctl.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: ctl.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  ctl.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   ctl.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  ctl.alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_slt:  ctl.alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sltu: ctl.alu_op = mips_pkg::alu_sltu;
          mips_pkg::fn_sll:  ctl.alu_op = mips_pkg::alu_sll; // Shift amount comes from shamt
          mips_pkg::fn_srl:  ctl.alu_op = mips_pkg::alu_srl;
          mips_pkg::fn_sra:  ctl.alu_op = mips_pkg::alu_sra;
          mips_pkg::fn_jr: begin
            ctl.reg_write = 1'b0;
            ctl.jump_reg  = 1'b1;
          end
          mips_pkg::fn_jalr: begin
            ctl.jump_reg = 1'b1; // Link goes to rd, which is usually 31
            ctl.link     = 1'b1;
          end
          default: ctl.reg_write = 1'b0; // Unknown funct writes nothing
        endcase
      end
      mips_pkg::op_addiu: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
      end
      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src_imm  = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op = (instr.i.opcode == mips_pkg::op_andi) ? mips_pkg::alu_and :
                     (instr.i.opcode == mips_pkg::op_ori)  ? mips_pkg::alu_or  :
                                                             mips_pkg::alu_xor;
      end
      mips_pkg::op_slti, mips_pkg::op_sltiu: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1; // sltiu still sign-extends, only the compare is unsigned
        ctl.alu_op = (instr.i.opcode == mips_pkg::op_slti) ? mips_pkg::alu_slt :
                                                              mips_pkg::alu_sltu;
      end
      mips_pkg::op_lui: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
        ctl.alu_op      = mips_pkg::alu_lui;
      end
      mips_pkg::op_beq, mips_pkg::op_bne: ctl.alu_op = mips_pkg::alu_sub; // rs minus rt
      mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu, mips_pkg::op_lh,
      mips_pkg::op_lhu: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1; // Address is rs plus offset
        ctl.mem_to_reg  = 1'b1;
        ctl.mem_read    = 1'b1;
        case (instr.i.opcode)
          mips_pkg::op_lb:  ctl.load_mode = mips_pkg::ld_byte;
          mips_pkg::op_lbu: ctl.load_mode = mips_pkg::ld_byte_u;
          mips_pkg::op_lh:  ctl.load_mode = mips_pkg::ld_half;
          mips_pkg::op_lhu: ctl.load_mode = mips_pkg::ld_half_u;
          default:          ctl.load_mode = mips_pkg::ld_word;
        endcase
      end
      mips_pkg::op_sw: begin
        ctl.alu_src_imm = 1'b1;
        ctl.mem_write   = 1'b1;
      end
      mips_pkg::op_j: ctl.jump = 1'b1;
      mips_pkg::op_jal: begin
        ctl.jump      = 1'b1;
        ctl.link      = 1'b1; // Destination falls back to link_reg
        ctl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mips_load_select.sv
`timescale 1ns/1ps
`default_nettype none

module mips_load_select (
  input  mips_pkg::load_mode_e mode,
  input  logic [1:0]           byte_offset,
  input  logic [31:0]          word,
  output logic [31:0]          y
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // Byte 0 sits in the low bits of the word
  assign sel_byte = word[8*byte_offset +: 8];
  assign sel_half = byte_offset[1] ? word[31:16] : word[15:0]; // Bit 0 of the offset is ignored

  always_comb begin
    case (mode)
      mips_pkg::ld_byte:   y = {{24{sel_byte[7]}}, sel_byte};
      mips_pkg::ld_byte_u: y = {24'd0, sel_byte};
      mips_pkg::ld_half:   y = {{16{sel_half[15]}}, sel_half};
      mips_pkg::ld_half_u: y = {16'd0, sel_half};
      default:             y = word; // lw returns the word unchanged
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
  input  mips_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       y,
  output logic              zero
);

  logic [31:0] diff;
  logic        lt_signed;
  logic        lt_unsigned;

  assign diff        = a - b;
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (op)
      mips_pkg::alu_add: begin
        y = a + b; // addu and addiu never trap
      end
      mips_pkg::alu_sub: begin
        y = diff;
      end
      mips_pkg::alu_and:  y = a & b;
      mips_pkg::alu_or:   y = a | b;
      mips_pkg::alu_xor:  y = a ^ b;
      mips_pkg::alu_nor:  y = ~(a | b);
      mips_pkg::alu_slt:  y = {31'd0, lt_signed};
      mips_pkg::alu_sltu: y = {31'd0, lt_unsigned};
      // Shifts move operand B, which holds rt
      mips_pkg::alu_sll:  y = b << shamt;
      mips_pkg::alu_srl:  y = b >> shamt;
      mips_pkg::alu_sra: begin
        y = $unsigned($signed(b) >>> shamt); // Sign bit copied in from the left
      end
      mips_pkg::alu_lui: begin
        y = {b[15:0], 16'h0000};
      end
      default: begin
        y = a + b;
      end
    endcase
  end

  // beq and bne ask for a subtract and test this flag
  assign zero = (y == 32'd0);

endmodule

`default_nettype wire

// File: logic/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        write_en,
  input  logic [4:0]  read_addr_a,
  input  logic [4:0]  read_addr_b,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b,
  output logic [31:0] reg_v0
);

  logic [31:0] regs [32];

  // Entry 0 is cleared by reset and never written, so $0 always reads zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  // Reads see the old value during the writing cycle
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

  assign reg_v0 = regs[mips_pkg::v0_reg]; // Observed from outside the core

endmodule

`default_nettype wire

// File: logic/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded control levels, valid for the whole cycle of the current instruction
interface ctrl_if;
  logic                 reg_write;    // Result goes to the register file
  logic                 reg_dst_rd;   // Destination is rd and not rt
  logic                 link;         // Write PC+8, to link_reg unless rd is chosen
  logic                 mem_to_reg;   // Writeback takes the load selector output
  logic                 alu_src_imm;  // ALU operand B is the immediate
  logic                 imm_zero_ext; // Logical immediates are zero-extended
  mips_pkg::alu_op_e    alu_op;
  mips_pkg::load_mode_e load_mode;
  logic                 take_branch;  // Branch condition holds
  logic                 jump;         // j or jal
  logic                 jump_reg;     // jr or jalr
  logic                 mem_write;    // Store, before the enable gating
  logic                 mem_read;     // Load, before the enable gating
  logic                 zero;         // ALU result is zero

  modport ctl (
    output reg_write, reg_dst_rd, link, mem_to_reg, alu_src_imm, imm_zero_ext,
    output alu_op, load_mode, take_branch, jump, jump_reg, mem_write, mem_read,
    input  zero
  );

  modport dp (
    input  reg_write, reg_dst_rd, link, mem_to_reg, alu_src_imm, imm_zero_ext,
    input  alu_op, load_mode, take_branch, jump, jump_reg, mem_write, mem_read,
    output zero
  );
endinterface

`default_nettype wire

// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // Primary opcode in bits 31 to 26
  typedef enum logic [5:0] {
    op_special = 6'b000000, // R-type, the real operation sits in funct
    op_j       = 6'b000010,
    op_jal     = 6'b000011,
    op_beq     = 6'b000100,
    op_bne     = 6'b000101,
    op_addiu   = 6'b001001,
    op_slti    = 6'b001010,
    op_sltiu   = 6'b001011,
    op_andi    = 6'b001100,
    op_ori     = 6'b001101,
    op_xori    = 6'b001110,
    op_lui     = 6'b001111,
    op_lb      = 6'b100000,
    op_lh      = 6'b100001,
    op_lw      = 6'b100011,
    op_lbu     = 6'b100100,
    op_lhu     = 6'b100101,
    op_sw      = 6'b101011
  } opcode_e;

  // Function field of the SPECIAL opcode
  typedef enum logic [5:0] {
    fn_sll  = 6'b000000, // An all-zero word is sll $0,$0,0 and acts as nop
    fn_srl  = 6'b000010,
    fn_sra  = 6'b000011,
    fn_jr   = 6'b001000,
    fn_jalr = 6'b001001,
    fn_addu = 6'b100001,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_xor  = 6'b100110,
    fn_slt  = 6'b101010,
    fn_sltu = 6'b101011
  } funct_e;

  // Operations the ALU knows
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  // Width and extension of a load result
  typedef enum logic [2:0] {
    ld_word, ld_byte, ld_byte_u, ld_half, ld_half_u
  } load_mode_e;

  localparam logic [31:0] reset_vector = 32'hBFC0_0000; // First fetch after reset
  localparam logic [4:0]  link_reg     = 5'd31;          // ra, written by jal
  localparam logic [4:0]  v0_reg       = 5'd2;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target; // Word index inside the current 256 MB region
  } j_fmt_t;

  // One instruction word seen in each of the three encodings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

endpackage

`default_nettype wire
